// File: tb/alu_patterns.txt
// Columns in hex: op a b imm expected_result expected_branch
// Op codes follow alu_op_e, branch is 1 for every non-branch op
00 0000000000000005 0000000000000007 0000000000000000 000000000000000c 1
00 ffffffffffffffff 0000000000000002 0000000000000000 0000000000000001 1
01 0000000000000003 0000000000000005 0000000000000000 fffffffffffffffe 1
01 8000000000000000 0000000000000001 0000000000000000 7fffffffffffffff 1
02 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0000000000000000 f000f000f000f000 1
03 f0f0f0f0f0f0f0f0 0f0f00000000000f 0000000000000000 fffff0f0f0f0f0ff 1
04 123456789abcdef0 ffffffffffffffff 0000000000000000 edcba9876543210f 1
05 0000000000000001 0000000000000000 0000000000000000 0000000000000001 1
05 0000000000000001 000000000000003f 0000000000000000 8000000000000000 1
05 00000000000000ff 0000000000000104 0000000000000000 0000000000000ff0 1
06 8000000000000000 000000000000003f 0000000000000000 0000000000000001 1
06 f000000000000000 0000000000000004 0000000000000000 0f00000000000000 1
07 8000000000000000 000000000000003f 0000000000000000 ffffffffffffffff 1
07 8000000000000000 0000000000000000 0000000000000000 8000000000000000 1
07 f000000000000000 0000000000000004 0000000000000000 ff00000000000000 1
07 7000000000000000 0000000000000004 0000000000000000 0700000000000000 1
08 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000001 1
09 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 1
0a 0000000000000005 0000000000000005 0000000000000000 0000000000000000 1
0a 0000000000000005 0000000000000006 0000000000000000 0000000000000000 0
0b 0000000000000005 0000000000000006 0000000000000000 0000000000000000 1
0b 0000000000000005 0000000000000005 0000000000000000 0000000000000000 0
0c ffffffffffffffff 0000000000000000 0000000000000000 0000000000000000 1
0d ffffffffffffffff 0000000000000000 0000000000000000 0000000000000000 0
0e ffffffffffffffff 0000000000000000 0000000000000000 0000000000000000 0
0e 0000000000000003 0000000000000003 0000000000000000 0000000000000000 1
0f ffffffffffffffff 0000000000000000 0000000000000000 0000000000000000 1
10 80ff017f8000ff81 0100010205ff0100 0000000000000000 0001000001000001 1
11 05fb05fb8080007f 0303fdfd01808581 0000000000000000 03fdfd03ff800081 1
12 1122334455667788 00ff000100000200 0000000000000000 1100330055660088 1
13 7f8010f081806401 01ff20f0000064fe 0000000000000000 7f8130e081817fff 1
13 7f8010f081806401 01ff20f0000064fe 000100ff00010001 7f7f3000817f7ffd 1
13 000000000000007f 0000000000000080 0000000000000001 0000000000000081 1

// File: filelist.f
design/alu_pkg.sv
design/alu_adder.sv
design/alu_shifter.sv
design/alu_polar_simd.sv
design/alu_unit.sv
tb/tb_alu_unit.sv

// File: Makefile
SRCS := $(wildcard design/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_alu_unit: filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_alu_unit -o Vtb_alu_unit -f filelist.f

run: obj_dir/Vtb_alu_unit
	@out=$$(./obj_dir/Vtb_alu_unit 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb/tb_alu_unit.sv
/* ALU unit testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_alu_unit;

    localparam int XLEN         = 64;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;

    logic             clk_i;
    logic             rst_i;
    logic             in_valid_i;
    logic             in_ready_o;
    alu_pkg::alu_op_e op_i;
    logic [XLEN-1:0]  operand_a_i;
    logic [XLEN-1:0]  operand_b_i;
    logic [XLEN-1:0]  imm_i;
    logic             out_valid_o;
    logic             out_ready_i;
    logic [XLEN-1:0]  result_o;
    logic             branch_o;

    // Pattern table, one entry per line of the file
    logic [4:0]      pat_op[$];
    logic [XLEN-1:0] pat_a[$];
    logic [XLEN-1:0] pat_b[$];
    logic [XLEN-1:0] pat_imm[$];
    logic [XLEN-1:0] pat_res[$];
    logic            pat_br[$];

    // Expected results of accepted patterns, oldest first
    logic [XLEN-1:0] exp_res_q[$];
    logic            exp_br_q[$];
    int              exp_idx_q[$];

    int              num_patterns;
    int              drive_idx;
    int              checked_cnt;
    bit              patterns_loaded;
    bit              accept_pending;
    bit              hold_pending;
    logic [XLEN-1:0] held_result;
    logic            held_branch;
    logic [31:0]     rand_state;

    alu_unit #(.XLEN(XLEN)) dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .branch_o    (branch_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_equal(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------
    // Pattern file
    // --------------------

    task automatic load_patterns();
        int              fd;
        int              fields;
        string           line;
        logic [XLEN-1:0] v_op;
        logic [XLEN-1:0] v_a;
        logic [XLEN-1:0] v_b;
        logic [XLEN-1:0] v_imm;
        logic [XLEN-1:0] v_res;
        logic [XLEN-1:0] v_br;
        fd = $fopen("tb/alu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file tb/alu_patterns.txt");
            $display("SOME TESTS FAILED");
            $fatal(1, "missing pattern file");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            // Skip blank lines and comment lines
            if (line.len() > 1 && line[0] != "/") begin
                fields = $sscanf(line, "%h %h %h %h %h %h", v_op, v_a, v_b, v_imm, v_res, v_br);
                if (fields != 6) begin
                    $display("Malformed pattern line: %s", line);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "bad pattern file");
                end
                pat_op.push_back(v_op[4:0]);
                pat_a.push_back(v_a);
                pat_b.push_back(v_b);
                pat_imm.push_back(v_imm);
                pat_res.push_back(v_res);
                pat_br.push_back(v_br[0]);
            end
        end
        $fclose(fd);
        num_patterns = pat_op.size();
    endtask

    // --------------------
    // Handshake monitor
    // --------------------

    // Runs at the rising edge, before the DUT registers update
    task automatic observe_edge();
        logic in_fire;
        logic out_fire;
        logic slot_full;
        in_fire   = in_valid_i && in_ready_o;
        out_fire  = out_valid_o && out_ready_i;
        // Slot occupancy from the items accepted and drained so far
        slot_full = (exp_res_q.size() != 0);
        if (accept_pending) begin
            check_equal(64'(out_valid_o), 64'd1, "no output one cycle after accept");
        end
        if (hold_pending) begin
            check_equal(result_o, held_result, "result_o changed while stalled");
            check_equal(64'(branch_o), 64'(held_branch), "branch_o changed while stalled");
        end
        check_equal(64'(out_valid_o), 64'(slot_full), "out_valid_o against items in flight");
        check_equal(64'(in_ready_o), 64'(!slot_full || out_ready_i), "in_ready_o rule");
        if (out_fire) begin
            check_equal(result_o, exp_res_q[0],
                        $sformatf("result of pattern %0d", exp_idx_q[0]));
            check_equal(64'(branch_o), 64'(exp_br_q[0]),
                        $sformatf("branch of pattern %0d", exp_idx_q[0]));
            void'(exp_res_q.pop_front());
            void'(exp_br_q.pop_front());
            void'(exp_idx_q.pop_front());
            checked_cnt++;
        end
        hold_pending   = out_valid_o && !out_ready_i;
        held_result    = result_o;
        held_branch    = branch_o;
        accept_pending = in_fire;
        if (in_fire) begin
            exp_res_q.push_back(pat_res[drive_idx]);
            exp_br_q.push_back(pat_br[drive_idx]);
            exp_idx_q.push_back(drive_idx);
            drive_idx++;
        end
    endtask

    // Random back-pressure, and random gaps between patterns
    task automatic drive_inputs();
        rand_state  = next_random(rand_state);
        out_ready_i = (rand_state[31:30] != 2'b00);
        // A pattern that was not taken stays on the inputs
        if (!in_valid_i || accept_pending) begin
            rand_state = next_random(rand_state);
            if (drive_idx < num_patterns && rand_state[31:30] != 2'b00) begin
                in_valid_i  = 1'b1;
                op_i        = alu_pkg::alu_op_e'(pat_op[drive_idx]);
                operand_a_i = pat_a[drive_idx];
                operand_b_i = pat_b[drive_idx];
                imm_i       = pat_imm[drive_idx];
            end else begin
                in_valid_i = 1'b0;
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        rst_i       = 1'b1;
        in_valid_i  = 1'b0;
        op_i        = alu_pkg::ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        out_ready_i = 1'b0;
        rand_state  = 32'hfc5b_8b2e;
        drive_idx   = 0;
        checked_cnt = 0;
        accept_pending = 1'b0;
        hold_pending   = 1'b0;
        load_patterns();
        patterns_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        check_equal(64'(out_valid_o), 64'd0, "out_valid_o after reset");
        check_equal(64'(in_ready_o), 64'd1, "in_ready_o after reset");

        drive_inputs();
        while (checked_cnt < num_patterns) begin
            @(posedge clk_i);
            observe_edge();
            #DRIVE_DELAY;
            drive_inputs();
        end

        if (num_patterns > 0 && exp_res_q.size() == 0 && drive_idx == num_patterns) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("Run ended with %0d patterns left unchecked", exp_res_q.size());
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, scaled by the number of patterns
    initial begin
        wait (patterns_loaded);
        #((num_patterns * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: only %0d of %0d patterns were checked", checked_cnt, num_patterns);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: design/alu_unit.sv
/* Registered ALU with handshake */

`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int unsigned XLEN = 64
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  logic [XLEN-1:0]  imm_i,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output logic [XLEN-1:0]  result_o,
    output logic             branch_o
);

    localparam int unsigned SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0] sum;
    logic            less;
    logic            branch_d;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] polar_res;
    logic [XLEN-1:0] result_d;
    logic            in_fire;

    // --------------------
    // Datapath
    // --------------------

    alu_adder #(.XLEN(XLEN)) adder_i (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .sum_o       (sum),
        .less_o      (less),
        .branch_o    (branch_d)
    );

    alu_shifter #(.XLEN(XLEN)) shifter_i (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .shamt_i     (operand_b_i[SHAMT_W-1:0]),
        .shift_o     (shift_res)
    );

    alu_polar_simd #(.XLEN(XLEN)) polar_i (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .polar_o     (polar_res)
    );

    // Result mux, branch compares give zero
    always_comb begin
        case (op_i)
            alu_pkg::ADD, alu_pkg::SUB:             result_d = sum;
            alu_pkg::ANDL:                          result_d = operand_a_i & operand_b_i;
            alu_pkg::ORL:                           result_d = operand_a_i | operand_b_i;
            alu_pkg::XORL:                          result_d = operand_a_i ^ operand_b_i;
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA: result_d = shift_res;
            alu_pkg::SLTS, alu_pkg::SLTU:           result_d = {{(XLEN - 1){1'b0}}, less};
            alu_pkg::PL_R, alu_pkg::PL_F,
            alu_pkg::PL_DECODE, alu_pkg::PL_G:      result_d = polar_res;
            default:                                result_d = '0;
        endcase
    end

    // --------------------
    // Output register
    // --------------------

    // Single slot, refilled in the cycle it drains
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            result_o <= result_d;
            branch_o <= branch_d;
        end
    end

    // --------------------
    // Assertions
    // --------------------

    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(branch_o))
        else $error("output changed while stalled");

    a_reset_empty: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("out_valid_o set after reset");

    a_op_known: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i |-> !$isunknown(op_i) && (op_i <= alu_pkg::PL_G))
        else $error("undefined op code on a valid input");

endmodule

`default_nettype wire

// File: design/alu_polar_simd.sv
/* Polar SIMD byte lane ops */

`timescale 1ns/1ps
`default_nettype none

module alu_polar_simd #(
    parameter int unsigned XLEN = 64
) (
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  logic [XLEN-1:0]  imm_i,
    output logic [XLEN-1:0]  polar_o
);

    localparam int unsigned LW    = alu_pkg::LANE_W;
    localparam int unsigned LANES = XLEN / LW;

    logic [XLEN-1:0] func_r;
    logic [XLEN-1:0] func_f;
    logic [XLEN-1:0] func_dec;
    logic [XLEN-1:0] func_g;

    // Clamp a 9-bit signed value to the symmetric lane range
    function automatic alu_pkg::lane_t sat_lane(input alu_pkg::lane_sum_t val);
        logic signed [LW:0] sval;
        sval = $signed(val);
        if (sval > alu_pkg::LANE_SAT_MAX) begin
            return alu_pkg::lane_t'(alu_pkg::LANE_SAT_MAX);
        end
        if (sval < -alu_pkg::LANE_SAT_MAX) begin
            return alu_pkg::lane_t'(-alu_pkg::LANE_SAT_MAX);
        end
        return val[LW-1:0];
    endfunction

    // --------------------
    // Per lane datapath
    // --------------------

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        alu_pkg::lane_t     lane_a;
        alu_pkg::lane_t     lane_b;
        alu_pkg::lane_t     abs_a;
        alu_pkg::lane_t     abs_b;
        alu_pkg::lane_t     min_abs;
        alu_pkg::lane_sum_t sum_ab;
        alu_pkg::lane_sum_t diff_ba;
        logic               sign_diff;

        assign lane_a = operand_a_i[i*LW +: LW];
        assign lane_b = operand_b_i[i*LW +: LW];

        // Negative a, unless b is exactly one
        assign func_r[i*LW +: LW] = (lane_a[LW-1] && (lane_b != alu_pkg::lane_t'(1))) ?
                                    alu_pkg::lane_t'(1) : '0;

        assign func_dec[i*LW +: LW] = (lane_b == '0) ? lane_a : '0;

        // 8-bit negation, so -128 keeps its value
        assign abs_a     = lane_a[LW-1] ? -lane_a : lane_a;
        assign abs_b     = lane_b[LW-1] ? -lane_b : lane_b;
        assign sign_diff = lane_a[LW-1] ^ lane_b[LW-1];
        assign min_abs   = (abs_a > abs_b) ? abs_b : abs_a;

        assign func_f[i*LW +: LW] = sign_diff ? -min_abs : min_abs;

        // Sign extended so the ninth bit flags overflow
        assign sum_ab  = {lane_a[LW-1], lane_a} + {lane_b[LW-1], lane_b};
        assign diff_ba = {lane_b[LW-1], lane_b} - {lane_a[LW-1], lane_a};

        assign func_g[i*LW +: LW] = (imm_i[i*LW +: LW] == '0) ? sat_lane(sum_ab) :
                                                               sat_lane(diff_ba);
    end

    // --------------------
    // Op select
    // --------------------

    always_comb begin
        case (op_i)
            alu_pkg::PL_R:      polar_o = func_r;
            alu_pkg::PL_F:      polar_o = func_f;
            alu_pkg::PL_DECODE: polar_o = func_dec;
            alu_pkg::PL_G:      polar_o = func_g;
            default:            polar_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/alu_shifter.sv
/* ALU barrel shifter */

`timescale 1ns/1ps
`default_nettype none

module alu_shifter #(
    parameter int unsigned XLEN = 64,
    localparam int unsigned SHAMT_W = $clog2(XLEN)
) (
    input  alu_pkg::alu_op_e   op_i,
    input  logic [XLEN-1:0]    operand_a_i,
    input  logic [SHAMT_W-1:0] shamt_i,
    output logic [XLEN-1:0]    shift_o
);

    logic            shift_left;
    logic            shift_arith;
    logic [XLEN-1:0] operand_a_rev;
    logic [XLEN-1:0] shift_in;
    logic [XLEN:0]   shift_in_ext;
    logic [XLEN:0]   shift_right;
    logic [XLEN-1:0] shift_left_res;

    assign shift_left  = (op_i == alu_pkg::SLL);
    assign shift_arith = (op_i == alu_pkg::SRA);

    // --------------------
    // Bit reversal
    // --------------------

    // Left shift is a right shift of the reversed operand
    for (genvar k = 0; k < XLEN; k++) begin : g_rev
        assign operand_a_rev[k]  = operand_a_i[XLEN-1-k];
        assign shift_left_res[k] = shift_right[XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : operand_a_i;

    // --------------------
    // Right shifter
    // --------------------

    // Extra top bit only carries the sign for SRA
    assign shift_in_ext = {shift_arith & shift_in[XLEN-1], shift_in};
    assign shift_right  = $unsigned($signed(shift_in_ext) >>> shamt_i);

    assign shift_o = shift_left ? shift_left_res : shift_right[XLEN-1:0];

endmodule

`default_nettype wire

// File: design/alu_adder.sv
/* ALU adder and branch compare */

`timescale 1ns/1ps
`default_nettype none

module alu_adder #(
    parameter int unsigned XLEN = 64
) (
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    output logic [XLEN-1:0]  sum_o,
    output logic             less_o,
    output logic             branch_o
);

    logic            negate_b;
    logic            signed_cmp;
    logic            zero_flag;
    logic [XLEN:0]   adder_in_a;
    logic [XLEN:0]   adder_in_b;
    logic [XLEN:0]   adder_ext;

    // --------------------
    // Adder
    // --------------------

    // Subtract for SUB and for the equality compares
    always_comb begin
        case (op_i)
            alu_pkg::SUB,
            alu_pkg::EQ,
            alu_pkg::NE: negate_b = 1'b1;
            default:     negate_b = 1'b0;
        endcase
    end

    // Extra low bit carries the +1 of the two's complement
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(XLEN + 1){negate_b}};
    assign adder_ext  = adder_in_a + adder_in_b;
    assign sum_o      = adder_ext[XLEN:1];
    assign zero_flag  = ~|sum_o;

    // --------------------
    // Compare
    // --------------------

    assign signed_cmp = (op_i == alu_pkg::SLTS) ||
                        (op_i == alu_pkg::LTS)  ||
                        (op_i == alu_pkg::GES);

    // Sign extend by one bit, zero extend for unsigned forms
    assign less_o = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                    $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

    // Branch resolution, taken by default for non-branch ops
    always_comb begin
        case (op_i)
            alu_pkg::EQ:  branch_o = zero_flag;
            alu_pkg::NE:  branch_o = ~zero_flag;
            alu_pkg::LTS,
            alu_pkg::LTU: branch_o = less_o;
            alu_pkg::GES,
            alu_pkg::GEU: branch_o = ~less_o;
            default:      branch_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/alu_pkg.sv
/* ALU shared definitions */

`default_nettype none

package alu_pkg;

    // --------------------
    // Widths
    // --------------------

    // Operation code width
    localparam int unsigned OP_W = 5;

    // Polar SIMD lane width, fixed for every XLEN
    localparam int unsigned LANE_W = 8;

    // Polar saturation bound, results clamp to +/- this value
    localparam int LANE_SAT_MAX = 127;

    // One signed polar lane
    typedef logic [LANE_W-1:0] lane_t;

    // Lane sum or difference with one extra bit for overflow
    typedef logic [LANE_W:0] lane_sum_t;

    // --------------------
    // Operations
    // --------------------

    typedef enum logic [OP_W-1:0] {
        // Adder
        ADD       = 5'd0,
        SUB       = 5'd1,
        // Bitwise logic
        ANDL      = 5'd2,
        ORL       = 5'd3,
        XORL      = 5'd4,
        // Shifts
        SLL       = 5'd5,
        SRL       = 5'd6,
        SRA       = 5'd7,
        // Set less than
        SLTS      = 5'd8,
        SLTU      = 5'd9,
        // Branch compares, result on the branch flag only
        EQ        = 5'd10,
        NE        = 5'd11,
        LTS       = 5'd12,
        LTU       = 5'd13,
        GES       = 5'd14,
        GEU       = 5'd15,
        // Polar byte lane ops
        PL_R      = 5'd16,
        PL_F      = 5'd17,
        PL_DECODE = 5'd18,
        PL_G      = 5'd19
    } alu_op_e;

endpackage

`default_nettype wire
